// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_cpu_top
FILELIST = files.f

SRCS = $(shell grep -v '^+' $(FILELIST)) cpu_config.svh
BIN = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out=$$(./$(BIN) 2>&1); echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

// File: cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// instruction memory, 64 words
`define CPU_INST_ADDR_W 6

// data memory, 32 words
`define CPU_DATA_ADDR_W 5

// first fetch after the program is loaded
`define CPU_RESET_PC 0

`endif

// File: cpu_golden.txt
// program count then program words, input count then input words,
// expected output count then expected output words; all values hex
23
24010005 2402FFFD 00221821 FC610000 00412023 // 0 to 4, add and sub
FC810000 0041282A FCA10000 3406F0F0 30C70FF0 // 5 to 9, slt and immediates
00C74026 FD010000 00064900 24200007 00095025 // 10 to 14, xor, sll, r0 write
FD410000 FC010000 AC040008 8C0B0008 FD610000 // 15 to 19, store and load
10220001 FC210000 14220001 FC410000 10000001 // 20 to 24, branches
FC610000 0800001C FC810000 240F0004 FC006000 // 25 to 29, jump and loop start
01836821 FDA10000 25EFFFFF 15E0FFFB 0000000D // 30 to 34, loop and halt
4
00000010 12345678 FFFFFFFF 7FFFFFFE
c
00000002 FFFFFFF8 00000001 0000F000
000F0F00 00000000 FFFFFFF8 00000005
00000012 1234567A 00000001 80000000

// File: cpu_top.sv
`timescale 1ns/1ps

module cpu_top
	import isa_pkg::*, pipe_pkg::*;
(
	input logic CLK,
	input logic reset,
	input word_t prog_word,
	input logic prog_last,
	input logic prog_valid,
	input word_t in_word,
	input logic in_valid,
	input logic out_ready,
	output logic prog_ready,
	output logic in_ready,
	output word_t out_word,
	output logic out_valid,
	output logic halted
);

	logic fetch_valid;
	fetch_pkt_t fetch;
	logic id_valid;
	fetch_pkt_t id_fetch;
	logic dec_valid;
	dec_pkt_t dec;
	logic op_valid;
	op_pkt_t op;
	logic ex_valid;
	ex_pkt_t ex;
	wb_t wb;
	logic retire;
	inst_addr_t next_pc;
	logic halt_req;

	inst_fetch u_inst_fetch (
		.CLK(CLK), .reset(reset),
		.prog_word(prog_word), .prog_last(prog_last), .prog_valid(prog_valid),
		.retire(retire), .next_pc(next_pc), .halt_req(halt_req),
		.prog_ready(prog_ready), .fetch_valid(fetch_valid), .fetch(fetch),
		.halted(halted)
	);

	// fetch to decode register
	always_ff @(posedge CLK) begin
		if (reset)
			id_valid <= 1'b0;
		else
			id_valid <= fetch_valid;
		if (fetch_valid)
			id_fetch <= fetch;
	end

	inst_decode u_inst_decode (
		.CLK(CLK), .reset(reset), .valid(id_valid), .fetch(id_fetch),
		.dec_valid(dec_valid), .dec(dec)
	);

	operand_fetch u_operand_fetch (
		.CLK(CLK), .reset(reset), .valid(dec_valid), .dec(dec), .wb(wb),
		.op_valid(op_valid), .op(op)
	);

	execution u_execution (
		.CLK(CLK), .reset(reset), .valid(op_valid), .op(op),
		.ex_valid(ex_valid), .ex(ex)
	);

	memory_access u_memory_access (
		.CLK(CLK), .reset(reset), .valid(ex_valid), .ex(ex),
		.in_word(in_word), .in_valid(in_valid), .out_ready(out_ready),
		.in_ready(in_ready), .out_word(out_word), .out_valid(out_valid),
		.wb(wb), .retire(retire), .next_pc(next_pc), .halt_req(halt_req)
	);

endmodule

// File: execution.sv
`timescale 1ns/1ps

module execution
	import isa_pkg::*, pipe_pkg::*;
(
	input logic CLK,
	input logic reset,
	input logic valid,
	input op_pkt_t op,
	output logic ex_valid,
	output ex_pkt_t ex
);

	word_t imm_ext;
	word_t alu_b;
	word_t alu_y;

	assign imm_ext = op.dec.ctrl.imm_zero_ext ? {16'b0, op.dec.imm}
		: {{16{op.dec.imm[15]}}, op.dec.imm};
	assign alu_b = op.dec.ctrl.alu_src_imm ? imm_ext : op.rt_val;

	always_comb begin
		case (op.dec.ctrl.alu_op)
			alu_add:  alu_y = op.rs_val + alu_b;
			alu_sub:  alu_y = op.rs_val - alu_b;
			alu_and:  alu_y = op.rs_val & alu_b;
			alu_or:   alu_y = op.rs_val | alu_b;
			alu_xor:  alu_y = op.rs_val ^ alu_b;
			alu_slt:  alu_y = {31'b0, $signed(op.rs_val) < $signed(alu_b)};
			alu_sll:  alu_y = alu_b << op.dec.shamt;
			default:  alu_y = op.rs_val;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (valid) begin
			ex.ctrl <= op.dec.ctrl;
			ex.alu_result <= alu_y;
			ex.store_data <= op.rt_val;
			ex.dest <= op.dec.dest;
			// word addressed, so the offset adds directly
			ex.branch_target <= op.dec.pc1 + inst_addr_t'(imm_ext);
			ex.jump_target <= inst_addr_t'(op.dec.jidx);
			ex.eq <= (op.rs_val == op.rt_val);
			ex.pc1 <= op.dec.pc1;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset)
			ex_valid <= 1'b0;
		else
			ex_valid <= valid;
	end

endmodule

// File: files.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
inst_fetch.sv
inst_decode.sv
operand_fetch.sv
execution.sv
memory_access.sv
cpu_top.sv
tb_cpu_top.sv

// File: inst_decode.sv
`timescale 1ns/1ps

module inst_decode
	import isa_pkg::*, pipe_pkg::*;
(
	input logic CLK,
	input logic reset,
	input logic valid,
	input fetch_pkt_t fetch,
	output logic dec_valid,
	output dec_pkt_t dec
);

	ctrl_t ctrl;
	reg_idx_t dest;

	always_comb begin
		opcode_t opcode;
		funct_t funct;
		opcode = opcode_t'(fetch.inst[31:26]);
		funct = funct_t'(fetch.inst[5:0]);
		ctrl = '0;
		dest = fetch.inst[20:16];
		case (opcode)
			op_special: begin
				dest = fetch.inst[15:11];
				ctrl.reg_write = 1'b1;
				case (funct)
					f_sll:  ctrl.alu_op = alu_sll;
					f_addu: ctrl.alu_op = alu_add;
					f_subu: ctrl.alu_op = alu_sub;
					f_and:  ctrl.alu_op = alu_and;
					f_or:   ctrl.alu_op = alu_or;
					f_xor:  ctrl.alu_op = alu_xor;
					f_slt:  ctrl.alu_op = alu_slt;
					f_halt: begin
						ctrl.reg_write = 1'b0;
						ctrl.halt = 1'b1;
					end
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			op_addiu: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			op_andi, op_ori: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.imm_zero_ext = 1'b1;
				ctrl.alu_op = (opcode == op_andi) ? alu_and : alu_or;
			end
			op_lw: begin
				ctrl.reg_write = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			op_sw: begin
				ctrl.mem_write = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			op_beq: ctrl.branch_eq = 1'b1;
			op_bne: ctrl.branch_ne = 1'b1;
			op_j:   ctrl.jump = 1'b1;
			op_io: begin
				// rt holds the selector here, so the input lands in rd
				dest = fetch.inst[15:11];
				if (fetch.inst[20:16] == 5'd0) begin
					ctrl.io_in = 1'b1;
					ctrl.reg_write = 1'b1;
				end else if (fetch.inst[20:16] == 5'd1) begin
					ctrl.io_out = 1'b1;
					ctrl.alu_op = alu_pass;
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset)
			dec_valid <= 1'b0;
		else
			dec_valid <= valid;
	end

	always_ff @(posedge CLK) begin
		if (valid) begin
			dec.ctrl <= ctrl;
			dec.rs <= fetch.inst[25:21];
			dec.rt <= fetch.inst[20:16];
			dec.dest <= dest;
			dec.shamt <= fetch.inst[10:6];
			dec.imm <= fetch.inst[15:0];
			dec.jidx <= fetch.inst[25:0];
			dec.pc1 <= fetch.pc1;
		end
	end

endmodule

// File: inst_fetch.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module inst_fetch
	import isa_pkg::*, pipe_pkg::*;
(
	input logic CLK,
	input logic reset,
	input word_t prog_word,
	input logic prog_last,
	input logic prog_valid,
	input logic retire,
	input inst_addr_t next_pc,
	input logic halt_req,
	output logic prog_ready,
	output logic fetch_valid,
	output fetch_pkt_t fetch,
	output logic halted
);

	word_t imem [2**`CPU_INST_ADDR_W];
	core_state_t state;
	inst_addr_t load_addr;
	inst_addr_t fetch_pc;
	logic prog_fire;
	logic fetch_en;

	assign prog_ready = (state == st_load);
	assign halted = (state == st_halt);
	assign prog_fire = prog_valid && prog_ready;

	// first fetch comes from the reset pc, later ones from the retiring instruction
	assign fetch_pc = (state == st_run) ? inst_addr_t'(`CPU_RESET_PC) : next_pc;
	assign fetch_en = (state == st_run) || (state == st_wait && retire && !halt_req);

	always_ff @(posedge CLK) begin
		if (prog_fire)
			imem[load_addr] <= prog_word;
		if (fetch_en) begin
			fetch.inst <= imem[fetch_pc];
			fetch.pc <= fetch_pc;
			fetch.pc1 <= fetch_pc + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= st_load;
			load_addr <= '0;
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= fetch_en;
			case (state)
				st_load: begin
					if (prog_fire) begin
						load_addr <= load_addr + 1'b1;
						if (prog_last)
							state <= st_run;
					end
				end
				st_run: state <= st_wait;
				st_wait: if (halt_req) state <= st_halt;
				default: ;
			endcase
		end
	end

	// retire only answers an outstanding fetch
	assert property (@(posedge CLK) disable iff (reset)
		retire |-> (state == st_wait));

	// one instruction in flight, so nothing retires next to a fetch
	assert property (@(posedge CLK) disable iff (reset)
		fetch_valid |-> !retire);

endmodule

// File: isa_pkg.sv
`include "cpu_config.svh"

package isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [`CPU_INST_ADDR_W-1:0] inst_addr_t;

	// op_io uses the rt field as selector: 0 reads the input stream into rd,
	// 1 sends rs to the output stream
	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_j       = 6'h02,
		op_beq     = 6'h04,
		op_bne     = 6'h05,
		op_addiu   = 6'h09,
		op_andi    = 6'h0c,
		op_ori     = 6'h0d,
		op_lw      = 6'h23,
		op_sw      = 6'h2b,
		op_io      = 6'h3f
	} opcode_t;

	typedef enum logic [5:0] {
		f_sll  = 6'h00,
		f_halt = 6'h0d,
		f_addu = 6'h21,
		f_subu = 6'h23,
		f_and  = 6'h24,
		f_or   = 6'h25,
		f_xor  = 6'h26,
		f_slt  = 6'h2a
	} funct_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sll,
		alu_pass
	} alu_op_t;

endpackage

// File: memory_access.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module memory_access
	import isa_pkg::*, pipe_pkg::*;
(
	input logic CLK,
	input logic reset,
	input logic valid,
	input ex_pkt_t ex,
	input word_t in_word,
	input logic in_valid,
	input logic out_ready,
	output logic in_ready,
	output word_t out_word,
	output logic out_valid,
	output wb_t wb,
	output logic retire,
	output inst_addr_t next_pc,
	output logic halt_req
);

	word_t dmem [2**`CPU_DATA_ADDR_W];
	logic [`CPU_DATA_ADDR_W-1:0] daddr;
	logic pend;
	logic active;
	logic done;
	logic taken;

	// ex holds still until retire, so a stalled instruction needs only pend
	assign active = valid || pend;
	assign in_ready = active && ex.ctrl.io_in;
	assign out_valid = active && ex.ctrl.io_out;
	assign out_word = ex.alu_result;
	assign done = active && !(in_ready && !in_valid) && !(out_valid && !out_ready);

	// byte address from the ALU, word granular memory
	assign daddr = ex.alu_result[`CPU_DATA_ADDR_W+1:2];
	assign taken = (ex.ctrl.branch_eq && ex.eq) || (ex.ctrl.branch_ne && !ex.eq);

	always_ff @(posedge CLK) begin
		if (valid && ex.ctrl.mem_write)
			dmem[daddr] <= ex.store_data;
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			pend <= 1'b0;
			retire <= 1'b0;
			halt_req <= 1'b0;
			wb.we <= 1'b0;
		end else begin
			pend <= active && !done;
			retire <= done;
			halt_req <= done && ex.ctrl.halt;
			wb.we <= done && ex.ctrl.reg_write && (ex.dest != '0);
			if (done) begin
				wb.dest <= ex.dest;
				if (ex.ctrl.io_in)
					wb.data <= in_word;
				else if (ex.ctrl.mem_read)
					wb.data <= dmem[daddr];
				else
					wb.data <= ex.alu_result;
				if (ex.ctrl.jump)
					next_pc <= ex.jump_target;
				else if (taken)
					next_pc <= ex.branch_target;
				else
					next_pc <= ex.pc1;
			end
		end
	end

	assert property (@(posedge CLK) disable iff (reset)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_word)));

	// no stream handshake stays open past retire
	assert property (@(posedge CLK) disable iff (reset)
		!(retire && (in_ready || out_valid)));

endmodule

// File: operand_fetch.sv
`timescale 1ns/1ps

module operand_fetch
	import isa_pkg::*, pipe_pkg::*;
(
	input logic CLK,
	input logic reset,
	input logic valid,
	input dec_pkt_t dec,
	input wb_t wb,
	output logic op_valid,
	output op_pkt_t op
);

	word_t regs [32];
	word_t rs_val;
	word_t rt_val;

	// r0 reads as zero whatever the array holds
	assign rs_val = (dec.rs == '0) ? '0 : regs[dec.rs];
	assign rt_val = (dec.rt == '0) ? '0 : regs[dec.rt];

	always_ff @(posedge CLK) begin
		if (wb.we)
			regs[wb.dest] <= wb.data;
		if (valid) begin
			op.dec <= dec;
			op.rs_val <= rs_val;
			op.rt_val <= rt_val;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset)
			op_valid <= 1'b0;
		else
			op_valid <= valid;
	end

	// memory stage must filter writes to r0
	assert property (@(posedge CLK) disable iff (reset)
		!(wb.we && wb.dest == '0));

endmodule

// File: pipe_pkg.sv
package pipe_pkg;
	import isa_pkg::*;

	typedef struct packed {
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic io_in;
		logic io_out;
		logic branch_eq;
		logic branch_ne;
		logic jump;
		logic halt;
		logic alu_src_imm;
		logic imm_zero_ext;
		alu_op_t alu_op;
	} ctrl_t;

	typedef struct packed {
		word_t inst;
		inst_addr_t pc;
		inst_addr_t pc1;
	} fetch_pkt_t;

	typedef struct packed {
		ctrl_t ctrl;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t dest;
		logic [4:0] shamt;
		logic [15:0] imm;
		logic [25:0] jidx;
		inst_addr_t pc1;
	} dec_pkt_t;

	typedef struct packed {
		dec_pkt_t dec;
		word_t rs_val;
		word_t rt_val;
	} op_pkt_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t alu_result;
		word_t store_data;
		reg_idx_t dest;
		inst_addr_t branch_target;
		inst_addr_t jump_target;
		logic eq;
		inst_addr_t pc1;
	} ex_pkt_t;

	typedef struct packed {
		logic we;
		reg_idx_t dest;
		word_t data;
	} wb_t;

	typedef enum logic [1:0] {
		st_load,
		st_run,
		st_wait,
		st_halt
	} core_state_t;

endpackage

// File: tb_cpu_top.sv
`timescale 1ns/1ps

module tb_cpu_top;

	logic CLK;
	logic reset;
	logic [31:0] prog_word;
	logic prog_last;
	logic prog_valid;
	logic prog_ready;
	logic [31:0] in_word;
	logic in_valid;
	logic in_ready;
	logic [31:0] out_word;
	logic out_valid;
	logic out_ready;
	logic halted;

	logic [31:0] gold [0:255];
	int prog_n;
	int in_base;
	int in_n;
	int out_base;
	int out_n;
	int n_out;
	int in_sent;
	int limit_cycles;

	cpu_top u_dut (
		.CLK(CLK), .reset(reset),
		.prog_word(prog_word), .prog_last(prog_last), .prog_valid(prog_valid),
		.in_word(in_word), .in_valid(in_valid), .out_ready(out_ready),
		.prog_ready(prog_ready), .in_ready(in_ready), .out_word(out_word),
		.out_valid(out_valid), .halted(halted)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			$display("STATUS: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic load_program();
		for (int i = 0; i < prog_n; i++) begin
			prog_valid = 1'b1;
			prog_word = gold[1 + i];
			prog_last = (i == prog_n - 1);
			do begin
				@(negedge CLK);
			end while (!prog_ready);
			@(posedge CLK);
			#2;
		end
		prog_valid = 1'b0;
		prog_last = 1'b0;
		@(negedge CLK);
		check_value(prog_ready, 1'b0, "prog_ready after the last word");
	endtask

	// random idle gaps between input words
	// long ones on odd words make the core wait on in_valid
	task automatic drive_inputs();
		int gap;
		for (int i = 0; i < in_n; i++) begin
			if (i % 2 == 1)
				gap = 40 + $urandom % 8;
			else
				gap = $urandom % 4;
			repeat (gap) begin
				@(posedge CLK);
				#2;
			end
			in_valid = 1'b1;
			in_word = gold[in_base + i];
			do begin
				@(negedge CLK);
			end while (!in_ready);
			@(posedge CLK);
			in_sent++;
			#2;
			in_valid = 1'b0;
		end
	endtask

	task automatic take_output();
		if (n_out >= out_n) begin
			$display("Error at %0t ns: an output word %h came after all expected ones",
				$time, out_word);
			$display("STATUS: FAIL");
			$fatal(1, "extra output");
		end
		check_value(out_word, gold[out_base + n_out], $sformatf("output word %0d", n_out));
		n_out++;
	endtask

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge CLK);
		$display("Error: the core did not halt within %0d cycles", limit_cycles);
		$display("STATUS: FAIL");
		$fatal(1, "timeout");
	end

	initial begin
		reset = 1'b1;
		prog_word = '0;
		prog_last = 1'b0;
		prog_valid = 1'b0;
		in_word = '0;
		in_valid = 1'b0;
		out_ready = 1'b0;
		n_out = 0;
		in_sent = 0;
		void'($urandom(77955));
		$readmemh("cpu_golden.txt", gold);
		prog_n = gold[0];
		in_n = gold[prog_n + 1];
		in_base = prog_n + 2;
		out_n = gold[in_base + in_n];
		out_base = in_base + in_n + 1;
		limit_cycles = (prog_n + in_n + out_n) * 20 + 200;

		repeat (10) @(posedge CLK);
		#2;
		reset = 1'b0;
		@(negedge CLK);
		check_value(prog_ready, 1'b1, "prog_ready after reset");
		check_value(out_valid, 1'b0, "out_valid after reset");
		check_value(in_ready, 1'b0, "in_ready after reset");
		check_value(halted, 1'b0, "halted after reset");
		@(posedge CLK);
		#2;

		fork
			drive_inputs();
		join_none
		load_program();

		// out_ready low on about a quarter of the cycles
		while (!halted) begin
			@(posedge CLK);
			#2;
			out_ready = ($urandom % 4) != 0;
			@(negedge CLK);
			if (out_valid && out_ready)
				take_output();
		end
		check_value(n_out, out_n, "output count at halt");
		check_value(in_sent, in_n, "input count at halt");

		repeat (50) begin
			@(negedge CLK);
			check_value(out_valid, 1'b0, "out_valid after halt");
			check_value(halted, 1'b1, "halted level");
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule
